/* verilog/egr_tqu_pkg.sv */
// shared sizes, word-type codes and the control-word layout of the tag queue
// imported by every block of the tag queuing path
`default_nettype none

package egr_tqu_pkg;

    ////////////////////////////////////////////////////////////
    // buffer sizes
    ////////////////////////////////////////////////////////////

    // one response word, control or data
    localparam int WORD_W = 64;

    // largest packet body
    localparam int MAX_DATA_WORDS = 4;

    // one control slot per held packet
    localparam int CTRL_DEPTH = 8;
    localparam int DATA_DEPTH = 32;

    localparam int CTRL_ADDR_W = $clog2(CTRL_DEPTH);
    localparam int DATA_ADDR_W = $clog2(DATA_DEPTH);

    // data-word count, 1 .. MAX_DATA_WORDS
    localparam int LEN_W = $clog2(MAX_DATA_WORDS + 1);

    // occupancy counters must reach the full depth
    localparam int CTRL_CNT_W = $clog2(CTRL_DEPTH + 1);
    localparam int DATA_CNT_W = $clog2(DATA_DEPTH + 1);

    ////////////////////////////////////////////////////////////
    // word type and pull FSM codes
    ////////////////////////////////////////////////////////////

    localparam logic WORD_TYPE_CTRL = 1'b0;
    localparam logic WORD_TYPE_DATA = 1'b1;

    // pull engine states
    localparam logic [1:0] PULL_IDLE = 2'd0;
    localparam logic [1:0] PULL_CTRL = 2'd1;
    localparam logic [1:0] PULL_DATA = 2'd2;

    ////////////////////////////////////////////////////////////
    // control word
    ////////////////////////////////////////////////////////////

    // stored as raw, decoded as meta by capture, write control and pull
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            // reserved, carried through untouched
            logic [WORD_W-LEN_W-5:0] tag;
            logic [3:0]              dest_port;
            // number of data words that follow
            logic [LEN_W-1:0]        data_len;
        } meta;
    } ctrl_word_u;

endpackage : egr_tqu_pkg

`default_nettype wire

/* verilog/rrsp_capture.sv */
// input register stage for read-response words
// tracks packet boundaries from the data_len of each control word
`default_nettype none
`timescale 1ns/10ps

module rrsp_capture (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rrsp_valid,
    input  logic                           rrsp_word_type,
    input  logic [egr_tqu_pkg::WORD_W-1:0] rrsp_word,
    output logic                           cap_valid,
    output logic                           cap_is_ctrl,
    output logic [egr_tqu_pkg::WORD_W-1:0] cap_word,
    output logic                           cap_last
);
    import egr_tqu_pkg::*;

    // data words still owed by the open packet, zero when none is open
    logic [LEN_W-1:0] words_left;
    logic             in_is_ctrl;
    ctrl_word_u       in_ctrl;

    assign in_ctrl.raw = rrsp_word;
    assign in_is_ctrl  = (rrsp_word_type == WORD_TYPE_CTRL);

    ////////////////////////////////////////////////////////////
    // strobes and packet tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid   <= 1'b0;
            cap_is_ctrl <= 1'b0;
            cap_last    <= 1'b0;
            words_left  <= '0;
        end else begin
            cap_valid   <= rrsp_valid;
            cap_is_ctrl <= rrsp_valid && in_is_ctrl;
            // final data word closes the packet
            cap_last    <= rrsp_valid && !in_is_ctrl && (words_left == LEN_W'(1));
            if (rrsp_valid && in_is_ctrl) begin
                // control word opens a packet
                words_left <= in_ctrl.meta.data_len;
            end else if (rrsp_valid) begin
                words_left <= words_left - LEN_W'(1);
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (rrsp_valid) begin
            cap_word <= rrsp_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // source protocol
    ////////////////////////////////////////////////////////////

    // data only inside an open packet
    a_data_in_pkt : assert property (@(posedge clk) disable iff (!rst_n)
        rrsp_valid && !in_is_ctrl |-> words_left != '0);

    // no new control word until the previous body is complete
    a_ctrl_no_pkt : assert property (@(posedge clk) disable iff (!rst_n)
        rrsp_valid && in_is_ctrl |-> words_left == '0);

    a_len_range : assert property (@(posedge clk) disable iff (!rst_n)
        rrsp_valid && in_is_ctrl |-> in_ctrl.meta.data_len inside {[1:MAX_DATA_WORDS]});

endmodule : rrsp_capture

`default_nettype wire

/* verilog/pkt_buf_wr_ctrl.sv */
// write side of the packet buffer: bank steering, occupancy and packet count
// also derives the stall level toward the response source
`default_nettype none
`timescale 1ns/10ps

module pkt_buf_wr_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cap_valid,
    input  logic                                cap_is_ctrl,
    input  logic [egr_tqu_pkg::WORD_W-1:0]      cap_word,
    input  logic                                cap_last,
    input  logic                                pull_start,
    input  logic                                pull_release,
    input  logic [egr_tqu_pkg::LEN_W-1:0]       pull_len,
    output logic                                ctrl_wr_en,
    output logic [egr_tqu_pkg::CTRL_ADDR_W-1:0] ctrl_wr_addr,
    output logic                                data_wr_en,
    output logic [egr_tqu_pkg::DATA_ADDR_W-1:0] data_wr_addr,
    output logic [egr_tqu_pkg::WORD_W-1:0]      wr_word,
    output logic                                pkt_avail,
    output logic                                rrsp_stall
);
    import egr_tqu_pkg::*;

    logic [CTRL_CNT_W-1:0] ctrl_occ;
    logic [DATA_CNT_W-1:0] data_occ;
    logic [CTRL_CNT_W-1:0] pkt_cnt;
    // last data word written, counted one cycle later
    logic                  wr_last_q;
    logic [CTRL_CNT_W-1:0] ctrl_used;
    logic [DATA_CNT_W-1:0] data_rsv;
    logic [DATA_CNT_W-1:0] data_used;
    ctrl_word_u            cap_ctrl;

    assign cap_ctrl.raw = cap_word;

    // write in the same cycle as the capture strobes
    assign ctrl_wr_en = cap_valid && cap_is_ctrl;
    assign data_wr_en = cap_valid && !cap_is_ctrl;
    assign wr_word    = cap_word;

    // whole packet body is reserved when its control word is written
    assign data_rsv = ctrl_wr_en ? DATA_CNT_W'(cap_ctrl.meta.data_len) : '0;

    ////////////////////////////////////////////////////////////
    // pointers and counts
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_wr_addr <= '0;
            data_wr_addr <= '0;
            ctrl_occ     <= '0;
            data_occ     <= '0;
            pkt_cnt      <= '0;
            wr_last_q    <= 1'b0;
        end else begin
            // pointers wrap at the bank depth
            ctrl_wr_addr <= ctrl_wr_addr + CTRL_ADDR_W'(ctrl_wr_en);
            data_wr_addr <= data_wr_addr + DATA_ADDR_W'(data_wr_en);
            ctrl_occ     <= ctrl_occ + CTRL_CNT_W'(ctrl_wr_en) - CTRL_CNT_W'(pull_release);
            data_occ     <= data_occ + data_rsv
                            - (pull_release ? DATA_CNT_W'(pull_len) : '0);
            wr_last_q    <= cap_valid && cap_last;
            pkt_cnt      <= pkt_cnt + CTRL_CNT_W'(wr_last_q) - CTRL_CNT_W'(pull_start);
        end
    end

    ////////////////////////////////////////////////////////////
    // levels
    ////////////////////////////////////////////////////////////

    assign pkt_avail = (pkt_cnt != '0);

    // pending control write counted so a stale count never admits one too many
    assign ctrl_used  = ctrl_occ + CTRL_CNT_W'(ctrl_wr_en);
    assign data_used  = data_occ + data_rsv;
    assign rrsp_stall = (ctrl_used >= CTRL_CNT_W'(CTRL_DEPTH)) ||
                        (data_used > DATA_CNT_W'(DATA_DEPTH - MAX_DATA_WORDS));

    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_occ <= CTRL_CNT_W'(CTRL_DEPTH) && data_occ <= DATA_CNT_W'(DATA_DEPTH));

    // pull engine never frees more than is held
    a_release_held : assert property (@(posedge clk) disable iff (!rst_n)
        pull_release |-> ctrl_occ != '0 && data_occ >= DATA_CNT_W'(pull_len));

endmodule : pkt_buf_wr_ctrl

`default_nettype wire

/* verilog/pkt_buf_bank.sv */
// simple dual-port buffer bank, one write port and one registered read port
// instantiated once for control words and once for data words
`default_nettype none
`timescale 1ns/10ps

module pkt_buf_bank #(
    parameter int ADDR_W = egr_tqu_pkg::DATA_ADDR_W
) (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic [ADDR_W-1:0]              wr_addr,
    input  logic [egr_tqu_pkg::WORD_W-1:0] wr_word,
    input  logic                           rd_en,
    input  logic [ADDR_W-1:0]              rd_addr,
    output logic [egr_tqu_pkg::WORD_W-1:0] rd_word
);
    import egr_tqu_pkg::*;

    logic [WORD_W-1:0] mem [2**ADDR_W];

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // read latency 1, output holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule : pkt_buf_bank

`default_nettype wire

/* verilog/tcu_pull.sv */
// pull engine toward the transmit controller
// replays one whole packet per accepted pull, then frees its buffer space
`default_nettype none
`timescale 1ns/10ps

module tcu_pull (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                tx_pull,
    input  logic                                pkt_avail,
    input  logic [egr_tqu_pkg::WORD_W-1:0]      ctrl_rd_word,
    input  logic [egr_tqu_pkg::WORD_W-1:0]      data_rd_word,
    output logic                                ctrl_rd_en,
    output logic [egr_tqu_pkg::CTRL_ADDR_W-1:0] ctrl_rd_addr,
    output logic                                data_rd_en,
    output logic [egr_tqu_pkg::DATA_ADDR_W-1:0] data_rd_addr,
    output logic                                pull_start,
    output logic                                pull_release,
    output logic [egr_tqu_pkg::LEN_W-1:0]       pull_len,
    output logic                                tx_valid,
    output logic                                tx_sop,
    output logic                                tx_eop,
    output egr_tqu_pkg::ctrl_word_u             tx_meta,
    output logic [egr_tqu_pkg::WORD_W-1:0]      tx_word
);
    import egr_tqu_pkg::*;

    logic [1:0]       state;
    // data reads issued for the current packet
    logic [LEN_W-1:0] rd_idx;
    logic             rd_last;
    ctrl_word_u       rd_ctrl;

    // control bank output holds through the data phase
    assign rd_ctrl.raw = ctrl_rd_word;

    // pull ignored while busy or empty
    assign pull_start = (state == PULL_IDLE) && tx_pull && pkt_avail;
    assign ctrl_rd_en = (state == PULL_CTRL);
    assign data_rd_en = (state == PULL_DATA);
    assign rd_last    = (rd_idx == rd_ctrl.meta.data_len - LEN_W'(1));

    ////////////////////////////////////////////////////////////
    // FSM and read pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= PULL_IDLE;
            rd_idx       <= '0;
            ctrl_rd_addr <= '0;
            data_rd_addr <= '0;
        end else begin
            case (state)
                PULL_IDLE: begin
                    if (pull_start) begin
                        state <= PULL_CTRL;
                    end
                end
                PULL_CTRL: begin
                    state  <= PULL_DATA;
                    rd_idx <= '0;
                end
                PULL_DATA: begin
                    // one data read per cycle
                    rd_idx <= rd_idx + LEN_W'(1);
                    if (rd_last) begin
                        state <= PULL_IDLE;
                    end
                end
                default: state <= PULL_IDLE;
            endcase
            ctrl_rd_addr <= ctrl_rd_addr + CTRL_ADDR_W'(ctrl_rd_en);
            data_rd_addr <= data_rd_addr + DATA_ADDR_W'(data_rd_en);
        end
    end

    ////////////////////////////////////////////////////////////
    // transmit side, aligned with the bank read data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid     <= 1'b0;
            tx_sop       <= 1'b0;
            tx_eop       <= 1'b0;
            pull_release <= 1'b0;
        end else begin
            tx_valid     <= data_rd_en;
            tx_sop       <= data_rd_en && (rd_idx == '0);
            tx_eop       <= data_rd_en && rd_last;
            // space freed the cycle after eop
            pull_release <= tx_eop;
        end
    end

    // metadata kept for the whole packet, also gives the release length
    always_ff @(posedge clk) begin
        if (data_rd_en && (rd_idx == '0)) begin
            tx_meta <= rd_ctrl;
        end
    end

    assign pull_len = tx_meta.meta.data_len;
    assign tx_word  = data_rd_word;

    // a bad stored length would run the data phase past the packet
    a_meta_len : assert property (@(posedge clk) disable iff (!rst_n)
        data_rd_en && (rd_idx == '0) |-> rd_ctrl.meta.data_len inside {[1:MAX_DATA_WORDS]});

endmodule : tcu_pull

`default_nettype wire

/* verilog/tag_queue_unit.sv */
// tag queuing unit top: response capture, packet buffer and transmit pull
// source side stalls on rrsp_stall, transmit side pulls whole packets
`default_nettype none
`timescale 1ns/10ps

module tag_queue_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rrsp_valid,
    input  logic                           rrsp_word_type,
    input  logic [egr_tqu_pkg::WORD_W-1:0] rrsp_word,
    input  logic                           tx_pull,
    output logic                           rrsp_stall,
    output logic                           pkt_avail,
    output logic                           tx_valid,
    output logic                           tx_sop,
    output logic                           tx_eop,
    output egr_tqu_pkg::ctrl_word_u        tx_meta,
    output logic [egr_tqu_pkg::WORD_W-1:0] tx_word
);
    import egr_tqu_pkg::*;

    // capture stage
    logic                   cap_valid;
    logic                   cap_is_ctrl;
    logic                   cap_last;
    logic [WORD_W-1:0]      cap_word;

    // bank ports
    logic                   ctrl_wr_en;
    logic [CTRL_ADDR_W-1:0] ctrl_wr_addr;
    logic                   data_wr_en;
    logic [DATA_ADDR_W-1:0] data_wr_addr;
    logic [WORD_W-1:0]      wr_word;
    logic                   ctrl_rd_en;
    logic [CTRL_ADDR_W-1:0] ctrl_rd_addr;
    logic [WORD_W-1:0]      ctrl_rd_word;
    logic                   data_rd_en;
    logic [DATA_ADDR_W-1:0] data_rd_addr;
    logic [WORD_W-1:0]      data_rd_word;

    // pull handshake with write control
    logic                   pull_start;
    logic                   pull_release;
    logic [LEN_W-1:0]       pull_len;

    rrsp_capture i_capture (.*);

    pkt_buf_wr_ctrl i_wr_ctrl (.*);

    pkt_buf_bank #(.ADDR_W(CTRL_ADDR_W)) i_ctrl_bank (
        .clk(clk), .wr_en(ctrl_wr_en), .wr_addr(ctrl_wr_addr), .wr_word(wr_word),
        .rd_en(ctrl_rd_en), .rd_addr(ctrl_rd_addr), .rd_word(ctrl_rd_word)
    );

    pkt_buf_bank #(.ADDR_W(DATA_ADDR_W)) i_data_bank (
        .clk(clk), .wr_en(data_wr_en), .wr_addr(data_wr_addr), .wr_word(wr_word),
        .rd_en(data_rd_en), .rd_addr(data_rd_addr), .rd_word(data_rd_word)
    );

    tcu_pull i_pull (.*);

endmodule : tag_queue_unit

`default_nettype wire

/* tb/tb_clk_gen.sv */
// clock and reset source for the tag queue testbench
// 100 ns clock, rst_n held low for the first 16 cycles
`default_nettype none
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // half of the 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // release on a falling edge, clear of the DUT sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* tb/tb_tag_queue_unit.sv */
// table-driven testbench for the tag queuing unit
// source model and pull agent drive the DUT, a negedge monitor checks each word
`default_nettype none
`timescale 1ns/10ps

module tb_tag_queue_unit;
    import egr_tqu_pkg::*;

    // row actions after the row's packet
    localparam int ACT_HOLD  = 0;
    localparam int ACT_PULL  = 1;
    localparam int ACT_DRAIN = 2;
    localparam int ACT_RND   = 3;
    // length codes beside 1 .. MAX_DATA_WORDS
    localparam int LEN_NONE  = 0;
    localparam int LEN_RND   = 7;
    localparam int NO_CHECK  = -1;
    localparam int MAX_ROWS  = 64;

    logic              clk;
    logic              rst_n;
    logic              rrsp_valid;
    logic              rrsp_word_type;
    logic [WORD_W-1:0] rrsp_word;
    logic              tx_pull;
    logic              rrsp_stall;
    logic              pkt_avail;
    logic              tx_valid;
    logic              tx_sop;
    logic              tx_eop;
    ctrl_word_u        tx_meta;
    logic [WORD_W-1:0] tx_word;

    // stimulus table, one packet per row
    int row_dest  [MAX_ROWS];
    int row_len   [MAX_ROWS];
    int row_act   [MAX_ROWS];
    int row_stall [MAX_ROWS];
    int row_avail [MAX_ROWS];
    int n_rows = 0;
    bit table_ready = 1'b0;

    // expected transmit stream in arrival order
    ctrl_word_u        exp_meta [$];
    logic [WORD_W-1:0] exp_word [$];

    // held packets as seen by the stall rule
    int held_cnt = 0;
    int held_sum = 0;
    // sent and not yet asked for
    int kept = 0;
    // pulls handed to the agent and not finished
    int pull_req = 0;
    int pkt_idx = 0;
    int seed = 81083;

    // monitor state
    int                words_out = 0;
    ctrl_word_u        cur_meta;
    logic [WORD_W-1:0] want_word;

    tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    tag_queue_unit i_dut (
        .clk(clk), .rst_n(rst_n), .rrsp_valid(rrsp_valid), .rrsp_word_type(rrsp_word_type),
        .rrsp_word(rrsp_word), .tx_pull(tx_pull), .rrsp_stall(rrsp_stall),
        .pkt_avail(pkt_avail), .tx_valid(tx_valid), .tx_sop(tx_sop), .tx_eop(tx_eop),
        .tx_meta(tx_meta), .tx_word(tx_word)
    );

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: tx_word is %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_meta(input ctrl_word_u got, input ctrl_word_u exp);
        if (got.raw !== exp.raw) begin
            $display("[FAIL] %0d ns: tx_meta is %h (port %0d len %0d), expected %h",
                     $time, got.raw, got.meta.dest_port, got.meta.data_len, exp.raw);
            stop_run();
        end
    endtask

    // full on control slots, or no room left for a maximal body
    function automatic bit stall_rule();
        return (held_cnt == CTRL_DEPTH) || (DATA_DEPTH - held_sum < MAX_DATA_WORDS);
    endfunction

    ////////////////////////////////////////////////////////////
    // table
    ////////////////////////////////////////////////////////////

    task automatic add_row(input int dest, input int len, input int act,
                           input int stall, input int avail);
        row_dest[n_rows]  = dest;
        row_len[n_rows]   = len;
        row_act[n_rows]   = act;
        row_stall[n_rows] = stall;
        row_avail[n_rows] = avail;
        n_rows++;
    endtask

    // fill up to stall, free one packet, refill, then empty
    task automatic add_fill_rows(input int len);
        for (int i = 0; i < CTRL_DEPTH - 1; i++) begin
            add_row(i, len, ACT_HOLD, 0, 1);
        end
        add_row(CTRL_DEPTH - 1, len, ACT_HOLD, 1, 1);
        add_row(0, LEN_NONE, ACT_PULL, 0, 1);
        add_row(9, len, ACT_HOLD, 1, 1);
        add_row(0, LEN_NONE, ACT_DRAIN, 0, 0);
    endtask

    task automatic build_table();
        // each length alone
        for (int l = 1; l <= MAX_DATA_WORDS; l++) begin
            add_row(l, l, ACT_PULL, 0, 0);
        end
        // three held, then pulled one at a time
        add_row(5, 2, ACT_HOLD, 0, 1);
        add_row(6, 3, ACT_HOLD, 0, 1);
        add_row(7, 1, ACT_HOLD, 0, 1);
        add_row(0, LEN_NONE, ACT_PULL, 0, 1);
        add_row(0, LEN_NONE, ACT_PULL, 0, 1);
        add_row(0, LEN_NONE, ACT_PULL, 0, 0);
        // control slot limit, then the 4-word case
        add_fill_rows(1);
        add_fill_rows(MAX_DATA_WORDS);
        // random lengths, pulls overlapping fills
        for (int i = 0; i < 16; i++) begin
            add_row(i, LEN_RND, ACT_RND, NO_CHECK, NO_CHECK);
        end
        add_row(0, LEN_NONE, ACT_DRAIN, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // source model and pull agent
    ////////////////////////////////////////////////////////////

    task automatic send_packet(input int dest, input int len);
        ctrl_word_u        ctrl;
        logic [WORD_W-1:0] word;
        ctrl.raw            = '0;
        ctrl.meta.tag       = {24'h5ac3e1, 32'(pkt_idx)};
        ctrl.meta.dest_port = 4'(dest);
        ctrl.meta.data_len  = LEN_W'(len);
        // control word held back while stalled
        @(posedge clk);
        while (rrsp_stall) begin
            @(posedge clk);
        end
        exp_meta.push_back(ctrl);
        rrsp_valid     <= 1'b1;
        rrsp_word_type <= WORD_TYPE_CTRL;
        rrsp_word      <= ctrl.raw;
        for (int w = 0; w < len; w++) begin
            @(posedge clk);
            // packet index high, word index low
            word = {32'(pkt_idx), 24'hd47a00, 8'(w)};
            exp_word.push_back(word);
            rrsp_word_type <= WORD_TYPE_DATA;
            rrsp_word      <= word;
        end
        @(posedge clk);
        rrsp_valid <= 1'b0;
        held_cnt += 1;
        held_sum += len;
        kept     += 1;
        pkt_idx  += 1;
    endtask

    task automatic request_pulls(input int n, input bit wait_done);
        kept     -= n;
        pull_req += n;
        if (wait_done) begin
            wait (pull_req == 0);
        end
    endtask

    task automatic run_pull_agent();
        int n;
        forever begin
            @(posedge clk);
            if (pull_req > 0 && pkt_avail) begin
                tx_pull <= 1'b1;
                @(posedge clk);
                tx_pull <= 1'b0;
                n = 1;
                while (!tx_sop && n < 12) begin
                    @(posedge clk);
                    n++;
                end
                if (!tx_sop) begin
                    $display("no packet came out after an accepted pull");
                    stop_run();
                end else if (n != 4) begin
                    $display("[FAIL] %0d ns: first word %0d cycles after pull, expected 3",
                             $time, n - 1);
                    stop_run();
                end
                n = 0;
                while (!tx_eop && n < 16) begin
                    @(posedge clk);
                    n++;
                end
                if (!tx_eop) begin
                    $display("a pulled packet never reached its last word");
                    stop_run();
                end
                // release cycle, then the counts settle
                repeat (2) @(posedge clk);
                pull_req -= 1;
            end
        end
    endtask

    task automatic apply_row(input int r);
        int len;
        len = row_len[r];
        if (len == LEN_RND) begin
            len = ($random(seed) & 3) + 1;
        end
        if (len != LEN_NONE) begin
            send_packet(row_dest[r], len);
        end
        case (row_act[r])
            ACT_PULL:  request_pulls(1, 1'b1);
            ACT_DRAIN: request_pulls(kept, 1'b1);
            ACT_RND: begin
                // forced once four wait, so the source never locks on stall
                if ((($random(seed) & 1) != 0) || (kept > 3)) begin
                    request_pulls(1, 1'b0);
                end
            end
            default: ;
        endcase
        repeat (8) @(posedge clk);
        @(negedge clk);
        if (row_stall[r] != NO_CHECK) begin
            if (row_stall[r] != int'(stall_rule())) begin
                $display("row %0d of the stimulus table does not follow the stall rule", r);
                stop_run();
            end
            check_level(rrsp_stall, row_stall[r] != 0, "rrsp_stall");
        end
        if (row_avail[r] != NO_CHECK) begin
            check_level(pkt_avail, row_avail[r] != 0, "pkt_avail");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // transmit monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n && tx_valid) begin
            if (exp_word.size() == 0) begin
                $display("the transmit side sent a word that was never written");
                stop_run();
            end
            check_level(tx_sop, words_out == 0, "tx_sop");
            if (tx_sop) begin
                cur_meta = exp_meta.pop_front();
                check_meta(tx_meta, cur_meta);
            end
            want_word = exp_word.pop_front();
            check_word(tx_word, want_word);
            words_out++;
            check_level(tx_eop, words_out == int'(cur_meta.meta.data_len), "tx_eop");
            if (tx_eop) begin
                words_out = 0;
                held_cnt -= 1;
                held_sum -= int'(cur_meta.meta.data_len);
            end
        end else if (rst_n && words_out != 0) begin
            // body words come back to back
            $display("the transmit side paused in the middle of a packet");
            stop_run();
        end
    end

    initial begin : watchdog
        wait (table_ready);
        repeat (n_rows * 40 + 2000) @(posedge clk);
        $display("watchdog: the tests did not finish within %0d clock cycles",
                 n_rows * 40 + 2000);
        stop_run();
    end

    initial begin : main
        rrsp_valid     = 1'b0;
        rrsp_word_type = WORD_TYPE_CTRL;
        rrsp_word      = '0;
        tx_pull        = 1'b0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_level(rrsp_stall, 1'b0, "rrsp_stall after reset");
        check_level(pkt_avail, 1'b0, "pkt_avail after reset");
        check_level(tx_valid, 1'b0, "tx_valid after reset");
        fork
            run_pull_agent();
        join_none
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        if (exp_meta.size() != 0 || exp_word.size() != 0) begin
            $display("some packets were sent but never came back");
            stop_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule : tb_tag_queue_unit

`default_nettype wire

/* src.f */
verilog/egr_tqu_pkg.sv
verilog/rrsp_capture.sv
verilog/pkt_buf_wr_ctrl.sv
verilog/pkt_buf_bank.sv
verilog/tcu_pull.sv
verilog/tag_queue_unit.sv
tb/tb_clk_gen.sv
tb/tb_tag_queue_unit.sv

/* Bender.yml */
package:
  name: tag_queue_unit

sources:
  - verilog/egr_tqu_pkg.sv
  - verilog/rrsp_capture.sv
  - verilog/pkt_buf_wr_ctrl.sv
  - verilog/pkt_buf_bank.sv
  - verilog/tcu_pull.sv
  - verilog/tag_queue_unit.sv

  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_tag_queue_unit.sv
